// ==== design/sysbus_pkg.sv ====
`default_nettype none

package sysbus_pkg;

    typedef logic [63:0] bus_word_t;
    typedef logic [12:0] bus_tag_t;
    typedef logic [3:0] sysbus_code_t;

    // only the low bit of the read code lands inside the 13-bit tag.
    localparam sysbus_code_t sysbus_read = 4'b0001;

    // target code for ordinary memory space.
    localparam sysbus_code_t sysbus_memory = 4'b0001;

    localparam int tag_op_shift = 12;
    localparam int tag_target_shift = 8;

    // source id of the requester sits in the low byte of the tag.
    localparam int tag_source_bits = 8;

endpackage

`default_nettype wire

// ==== design/cache_line_pkg.sv ====
`default_nettype none

package cache_line_pkg;

    localparam int beats_per_line = 8;
    localparam int beat_bits = 64;
    localparam int line_bits = beats_per_line * beat_bits;

    // a line is 64 bytes, so the low six address bits are dropped.
    localparam int line_offset_bits = 6;

    typedef logic [line_bits-1:0] line_t;
    typedef logic [63:0] line_addr_t;
    typedef logic [$clog2(beats_per_line)-1:0] beat_idx_t;

endpackage

`default_nettype wire

// ==== design/line_fetch_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fetch_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic abtr_grant,
    input  logic resp_cyc,
    input  logic last_beat,
    output logic abtr_reqcyc,
    output logic req_cyc,
    output logic resp_ack,
    output logic bus_busy,
    output logic ready,
    output logic beat_clear,
    output logic beat_take
);

    typedef enum logic [2:0]
    {
        idle,
        arbitrate,
        request,
        wait_resp,
        collect,
        done
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            idle:      if (enable) next_state = arbitrate;
            arbitrate: if (abtr_grant) next_state = request;
            request:   next_state = wait_resp;
            wait_resp: if (resp_cyc) next_state = collect;
            collect:   if (beat_take && last_beat) next_state = done;
            done:      if (enable) next_state = arbitrate; // a new fetch may start from ready.
            default:   next_state = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    assign abtr_reqcyc = (state == arbitrate);
    assign req_cyc     = (state == request);   // the request is a single cycle.
    assign resp_ack    = (state == collect);
    assign bus_busy    = (state == request) || (state == wait_resp) || (state == collect);
    assign ready       = (state == done);

    // the counter restarts while the request goes out, before any beat can arrive.
    assign beat_clear = (state == request);

    // a beat moves only when the memory offers one and the fetcher acknowledges it.
    assign beat_take = resp_ack && resp_cyc;

endmodule

`default_nettype wire

// ==== design/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter
    import cache_line_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clear,
    input  logic      take,
    output beat_idx_t index,
    output logic      last
);

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            index <= '0;
        end
        else if (take)
        begin
            index <= index + beat_idx_t'(1); // wraps to zero after the last beat.
        end
    end

    assign last = (index == beat_idx_t'(beats_per_line - 1));

endmodule

`default_nettype wire

// ==== design/line_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_assembler
    import sysbus_pkg::*;
    import cache_line_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      take,
    input  beat_idx_t index,
    input  bus_word_t word,
    output line_t     line
);

    // beat k fills bits 64k up to 64k+63, the rest of the line is left alone.
    // the register keeps its contents between fetches, so data stays stable
    // while the client reads it.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line <= '0;
        end
        else if (take)
        begin
            line[index*beat_bits +: beat_bits] <= word;
        end
    end

endmodule

`default_nettype wire

// ==== design/line_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fetcher
    import sysbus_pkg::*;
    import cache_line_pkg::*;
#(
    parameter logic [tag_source_bits-1:0] source_id = '0
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  line_addr_t addr,
    output logic       ready,
    output line_t      data,
    input  logic       abtr_grant,
    output logic       abtr_reqcyc,
    output logic       bus_busy,
    output logic       req_cyc,
    output logic       resp_ack,
    output bus_word_t  req,
    output bus_tag_t   req_tag,
    input  logic       resp_cyc,
    input  bus_word_t  resp
);

    logic       accept;
    logic       beat_clear;
    logic       beat_take;
    logic       last_beat;
    beat_idx_t  beat_index;
    line_addr_t line_addr;

    // the fsm only takes an enable while idle or ready, which are the states
    // where it neither asks for the bus nor holds it.
    assign accept = enable && !abtr_reqcyc && !bus_busy;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            line_addr <= {addr[$bits(line_addr_t)-1:line_offset_bits],
                          {line_offset_bits{1'b0}}};
        end
    end

    assign req = line_addr;
    assign req_tag = (bus_tag_t'(sysbus_read) << tag_op_shift)
                   | (bus_tag_t'(sysbus_memory) << tag_target_shift)
                   | bus_tag_t'(source_id);

    line_fetch_fsm u_fsm
    (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .abtr_grant  (abtr_grant),
        .resp_cyc    (resp_cyc),
        .last_beat   (last_beat),
        .abtr_reqcyc (abtr_reqcyc),
        .req_cyc     (req_cyc),
        .resp_ack    (resp_ack),
        .bus_busy    (bus_busy),
        .ready       (ready),
        .beat_clear  (beat_clear),
        .beat_take   (beat_take)
    );

    beat_counter u_beat_counter
    (
        .clk   (clk),
        .reset (reset),
        .clear (beat_clear),
        .take  (beat_take),
        .index (beat_index),
        .last  (last_beat)
    );

    line_assembler u_line_assembler
    (
        .clk   (clk),
        .reset (reset),
        .take  (beat_take),
        .index (beat_index),
        .word  (resp),
        .line  (data)
    );

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import sysbus_pkg::*;
#(
    parameter int arb_clients = 2
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      c0_reqcyc,
    input  logic      c0_busy,
    input  logic      c0_req_cyc,
    input  logic      c0_resp_ack,
    input  bus_word_t c0_req,
    input  bus_tag_t  c0_req_tag,
    output logic      c0_grant,
    output logic      c0_resp_cyc,
    output bus_word_t c0_resp,
    input  logic      c1_reqcyc,
    input  logic      c1_busy,
    input  logic      c1_req_cyc,
    input  logic      c1_resp_ack,
    input  bus_word_t c1_req,
    input  bus_tag_t  c1_req_tag,
    output logic      c1_grant,
    output logic      c1_resp_cyc,
    output bus_word_t c1_resp,
    output logic      main_bus_reqcyc,
    output bus_word_t main_bus_req,
    output bus_tag_t  main_bus_reqtag,
    input  logic      main_bus_respcyc,
    input  bus_word_t main_bus_resp,
    output logic      main_bus_respack
);

    typedef logic [$clog2(arb_clients)-1:0] client_t;
    typedef enum logic [1:0] {arb_free, arb_grant, arb_hold} arb_state_t;

    arb_state_t state;
    client_t    owner;
    client_t    last_served;
    client_t    winner;
    logic       owned;
    logic       owner_busy;
    logic       sel1;

    // with both asking, the client that did not get the last grant wins.
    always_comb
    begin
        if (c0_reqcyc && c1_reqcyc)
            winner = (last_served == client_t'(0)) ? client_t'(1) : client_t'(0);
        else
            winner = c1_reqcyc ? client_t'(1) : client_t'(0);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= arb_free;
            owner       <= client_t'(0);
            last_served <= client_t'(1); // so the instruction side goes first.
        end
        else
        begin
            case (state)
                arb_free:
                begin
                    if (c0_reqcyc || c1_reqcyc)
                    begin
                        state       <= arb_grant;
                        owner       <= winner;
                        last_served <= winner;
                    end
                end
                arb_grant: state <= arb_hold; // owner raises busy from the next cycle on.
                arb_hold:  if (!owner_busy) state <= arb_free;
                default:   state <= arb_free;
            endcase
        end
    end

    assign sel1       = (owner == client_t'(1));
    assign owned      = (state == arb_hold);
    assign owner_busy = sel1 ? c1_busy : c0_busy;

    assign c0_grant = (state == arb_grant) && !sel1;
    assign c1_grant = (state == arb_grant) && sel1;

    assign main_bus_reqcyc  = owned && (sel1 ? c1_req_cyc : c0_req_cyc);
    assign main_bus_req     = sel1 ? c1_req : c0_req;
    assign main_bus_reqtag  = sel1 ? c1_req_tag : c0_req_tag;
    assign main_bus_respack = owned && (sel1 ? c1_resp_ack : c0_resp_ack);

    // only the owner sees beats offered, the data word itself goes to both.
    assign c0_resp_cyc = owned && !sel1 && main_bus_respcyc;
    assign c1_resp_cyc = owned && sel1 && main_bus_respcyc;
    assign c0_resp     = main_bus_resp;
    assign c1_resp     = main_bus_resp;

endmodule

`default_nettype wire

// ==== design/fetch_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem
    import sysbus_pkg::*;
    import cache_line_pkg::*;
#(
    parameter logic [tag_source_bits-1:0] i_source_id = 8'd0,
    parameter logic [tag_source_bits-1:0] d_source_id = 8'd1,
    parameter int arb_clients = 2
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_enable,
    input  line_addr_t i_addr,
    output logic       i_ready,
    output line_t      i_data,
    input  logic       d_enable,
    input  line_addr_t d_addr,
    output logic       d_ready,
    output line_t      d_data,
    output logic       main_bus_reqcyc,
    output bus_word_t  main_bus_req,
    output bus_tag_t   main_bus_reqtag,
    input  logic       main_bus_respcyc,
    input  bus_word_t  main_bus_resp,
    output logic       main_bus_respack
);

    logic      i_grant;
    logic      i_reqcyc;
    logic      i_busy;
    logic      i_req_cyc;
    logic      i_resp_ack;
    bus_word_t i_req;
    bus_tag_t  i_req_tag;
    logic      i_resp_cyc;
    bus_word_t i_resp;
    logic      d_grant;
    logic      d_reqcyc;
    logic      d_busy;
    logic      d_req_cyc;
    logic      d_resp_ack;
    bus_word_t d_req;
    bus_tag_t  d_req_tag;
    logic      d_resp_cyc;
    bus_word_t d_resp;

    line_fetcher #(.source_id(i_source_id)) u_i_fetcher
    (
        .clk (clk), .reset (reset), .enable (i_enable), .addr (i_addr),
        .ready (i_ready), .data (i_data), .abtr_grant (i_grant),
        .abtr_reqcyc (i_reqcyc), .bus_busy (i_busy), .req_cyc (i_req_cyc),
        .resp_ack (i_resp_ack), .req (i_req), .req_tag (i_req_tag),
        .resp_cyc (i_resp_cyc), .resp (i_resp)
    );

    line_fetcher #(.source_id(d_source_id)) u_d_fetcher
    (
        .clk (clk), .reset (reset), .enable (d_enable), .addr (d_addr),
        .ready (d_ready), .data (d_data), .abtr_grant (d_grant),
        .abtr_reqcyc (d_reqcyc), .bus_busy (d_busy), .req_cyc (d_req_cyc),
        .resp_ack (d_resp_ack), .req (d_req), .req_tag (d_req_tag),
        .resp_cyc (d_resp_cyc), .resp (d_resp)
    );

    // client 0 is the instruction side, client 1 the data side.
    bus_arbiter #(.arb_clients(arb_clients)) u_arbiter
    (
        .clk (clk), .reset (reset),
        .c0_reqcyc (i_reqcyc), .c0_busy (i_busy), .c0_req_cyc (i_req_cyc),
        .c0_resp_ack (i_resp_ack), .c0_req (i_req), .c0_req_tag (i_req_tag),
        .c0_grant (i_grant), .c0_resp_cyc (i_resp_cyc), .c0_resp (i_resp),
        .c1_reqcyc (d_reqcyc), .c1_busy (d_busy), .c1_req_cyc (d_req_cyc),
        .c1_resp_ack (d_resp_ack), .c1_req (d_req), .c1_req_tag (d_req_tag),
        .c1_grant (d_grant), .c1_resp_cyc (d_resp_cyc), .c1_resp (d_resp),
        .main_bus_reqcyc (main_bus_reqcyc), .main_bus_req (main_bus_req),
        .main_bus_reqtag (main_bus_reqtag), .main_bus_respcyc (main_bus_respcyc),
        .main_bus_resp (main_bus_resp), .main_bus_respack (main_bus_respack)
    );

endmodule

`default_nettype wire

// ==== test/tb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model
    import sysbus_pkg::*;
    import cache_line_pkg::*;
#(
    parameter logic [31:0] seed = 32'd63
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      reqcyc,
    input  bus_word_t req,
    input  bus_tag_t  reqtag,
    output logic      respcyc,
    output bus_word_t resp,
    input  logic      respack
);

    // every request cycle is logged, so a request held too long shows up twice.
    bus_word_t req_addr_log[$];
    bus_tag_t  req_tag_log[$];

    logic [31:0] rand_state;
    logic        serving;
    bus_word_t   line_addr;
    int          beat;
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bus_word_t beat_word(input bus_word_t addr, input int k);
        return addr ^ (64'(k) * 64'h0101_0101_0101_0101);
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            rand_state <= seed;
            serving <= 1'b0;
            respcyc <= 1'b0;
            resp <= '0;
            beat <= 0;
            delay <= 0;
        end
        else
        begin
            rand_state <= lcg_next(rand_state);
            if (reqcyc)
            begin
                req_addr_log.push_back(req);
                req_tag_log.push_back(reqtag);
            end
            if (!serving)
            begin
                if (reqcyc)
                begin
                    serving <= 1'b1;
                    line_addr <= req;
                    beat <= 0;
                    delay <= int'(rand_state[20:18]); // first beat comes after 0 to 7 cycles.
                end
            end
            else if (respcyc && respack)
            begin
                if (beat == beats_per_line - 1)
                begin
                    respcyc <= 1'b0;
                    serving <= 1'b0;
                end
                else if (rand_state[17:16] == 2'd0)
                begin
                    resp <= beat_word(line_addr, beat + 1); // next beat back to back.
                    beat <= beat + 1;
                end
                else
                begin
                    respcyc <= 1'b0;
                    beat <= beat + 1;
                    delay <= int'(rand_state[17:16]) - 1;
                end
            end
            else if (!respcyc)
            begin
                if (delay != 0)
                    delay <= delay - 1;
                else
                begin
                    respcyc <= 1'b1;
                    resp <= beat_word(line_addr, beat);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_fetch_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsystem
    import sysbus_pkg::*;
    import cache_line_pkg::*;
();

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        i_enable = 1'b0;
    logic        d_enable = 1'b0;
    line_addr_t  i_addr = '0;
    line_addr_t  d_addr = '0;
    logic        i_ready;
    logic        d_ready;
    line_t       i_data;
    line_t       d_data;
    logic        main_bus_reqcyc;
    bus_word_t   main_bus_req;
    bus_tag_t    main_bus_reqtag;
    logic        main_bus_respcyc;
    bus_word_t   main_bus_resp;
    logic        main_bus_respack;
    line_t       i_expected;
    line_t       d_expected;
    line_t       i_data_q;
    line_t       d_data_q;
    logic        i_ready_q;
    logic        d_ready_q;
    int          i_done;
    int          d_done;
    int          seen;
    int          last_grant;
    logic [31:0] rand_state;

    fetch_subsystem i_fetch_subsystem
    (
        .clk (clk), .reset (reset),
        .i_enable (i_enable), .i_addr (i_addr), .i_ready (i_ready), .i_data (i_data),
        .d_enable (d_enable), .d_addr (d_addr), .d_ready (d_ready), .d_data (d_data),
        .main_bus_reqcyc (main_bus_reqcyc), .main_bus_req (main_bus_req),
        .main_bus_reqtag (main_bus_reqtag), .main_bus_respcyc (main_bus_respcyc),
        .main_bus_resp (main_bus_resp), .main_bus_respack (main_bus_respack)
    );

    tb_memory_model #(.seed(32'd63)) u_memory_model
    (
        .clk (clk), .reset (reset), .reqcyc (main_bus_reqcyc), .req (main_bus_req),
        .reqtag (main_bus_reqtag), .respcyc (main_bus_respcyc), .resp (main_bus_resp),
        .respack (main_bus_respack)
    );

    initial
    begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // beat k of a line is the aligned address xor k in every byte.
    function automatic line_t expected_line(input line_addr_t addr);
        line_t      line;
        line_addr_t base;
        base = {addr[63:6], 6'b0};
        for (int k = 0; k < 8; k++)
            line[k*64 +: 64] = base ^ (64'(k) * 64'h0101_0101_0101_0101);
        return line;
    endfunction

    // read code from bit 12 up, memory code in bits 8 to 11, source id below.
    function automatic bus_tag_t expected_tag(input int source);
        return bus_tag_t'({sysbus_read, sysbus_memory, 8'(source)});
    endfunction

    task automatic check_value(input string name, input logic [511:0] expected,
                               input logic [511:0] actual);
        if (expected !== actual)
        begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "check %s failed", name);
        end
    endtask

    task automatic wait_fetches(input int i_target, input int d_target, input string what);
        int cycles;
        cycles = 0;
        while ((i_done < i_target || d_done < d_target) && cycles < 400)
        begin
            @(posedge clk);
            cycles++;
        end
        if (i_done < i_target || d_done < d_target)
        begin
            $display("timeout: %s did not reach ready within 400 cycles", what);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout in %s", what);
        end
    endtask

    task automatic start_fetches(input logic do_i, input logic do_d,
                                 input line_addr_t ia, input line_addr_t da);
        @(posedge clk);
        i_enable <= do_i;
        d_enable <= do_d;
        if (do_i)
        begin
            i_addr <= ia;
            i_expected <= expected_line(ia);
        end
        if (do_d)
        begin
            d_addr <= da;
            d_expected <= expected_line(da);
        end
        @(posedge clk);
        i_enable <= 1'b0;
        d_enable <= 1'b0;
    endtask

    task automatic draw_address(output line_addr_t addr);
        rand_state = lcg_next(rand_state);
        addr[63:32] = rand_state;
        rand_state = lcg_next(rand_state);
        addr[31:0] = rand_state;
    endtask

    // with both sides asking at once, the side not served last goes first.
    task automatic check_pair(input string name);
        int first;
        first = (last_grant == 0) ? 1 : 0;
        check_value({name, " count"}, 512'(seen + 2),
                    512'(u_memory_model.req_tag_log.size()));
        check_value({name, " first tag"}, 512'(expected_tag(first)),
                    512'(u_memory_model.req_tag_log[seen]));
        check_value({name, " second tag"}, 512'(expected_tag(1 - first)),
                    512'(u_memory_model.req_tag_log[seen + 1]));
        last_grant = 1 - first;
        seen = seen + 2;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            i_ready_q <= 1'b0;
            d_ready_q <= 1'b0;
            i_done <= 0;
            d_done <= 0;
        end
        else
        begin
            i_ready_q <= i_ready;
            d_ready_q <= d_ready;
            i_data_q <= i_data;
            d_data_q <= d_data;
            if (i_ready && !i_ready_q)
            begin
                check_value("instruction line", i_expected, i_data);
                i_done <= i_done + 1;
            end
            if (d_ready && !d_ready_q)
            begin
                check_value("data line", d_expected, d_data);
                d_done <= d_done + 1;
            end
            if (i_ready && i_ready_q)
                check_value("instruction hold", i_data_q, i_data); // stable while ready.
            if (d_ready && d_ready_q)
                check_value("data hold", d_data_q, d_data);
        end
    end

    initial
    begin
        line_addr_t ia;
        line_addr_t da;
        rand_state = 32'd63;
        last_grant = 0;
        seen = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset outputs", 512'(0),
                    512'({i_ready, d_ready, main_bus_reqcyc, main_bus_respack}));

        start_fetches(1'b1, 1'b0, 64'h0000_1234_5678_9a77, '0);
        wait_fetches(1, 0, "unaligned instruction fetch");
        check_value("single count", 512'(1), 512'(u_memory_model.req_addr_log.size()));
        check_value("single address", 512'(64'h0000_1234_5678_9a40),
                    512'(u_memory_model.req_addr_log[0]));
        check_value("single tag", 512'(expected_tag(0)), 512'(u_memory_model.req_tag_log[0]));
        seen = 1;

        start_fetches(1'b1, 1'b1, 64'h0000_0000_8000_0123, 64'h0000_00ff_0000_0fff);
        wait_fetches(2, 1, "simultaneous fetches");
        check_pair("simultaneous");

        // the second enable lands while the first fetch still waits for the bus.
        start_fetches(1'b1, 1'b0, 64'h0000_0000_0040_1000, '0);
        @(posedge clk);
        i_addr <= 64'h0000_0000_0bad_0000;
        i_enable <= 1'b1;
        @(posedge clk);
        i_enable <= 1'b0;
        wait_fetches(3, 1, "fetch with ignored enable");
        repeat (4) @(posedge clk);
        check_value("ignored enable count", 512'(seen + 1),
                    512'(u_memory_model.req_tag_log.size()));
        last_grant = 0;
        seen = seen + 1;

        // a lone data fetch leaves the data side as the last one served.
        start_fetches(1'b0, 1'b1, '0, 64'h0000_0000_0007_ffc5);
        wait_fetches(3, 2, "data-side fetch");
        check_value("data count", 512'(seen + 1), 512'(u_memory_model.req_tag_log.size()));
        check_value("data address", 512'(64'h0000_0000_0007_ffc0),
                    512'(u_memory_model.req_addr_log[seen]));
        check_value("data tag", 512'(expected_tag(1)), 512'(u_memory_model.req_tag_log[seen]));
        last_grant = 1;
        seen = seen + 1;

        for (int n = 0; n < 50; n++)
        begin
            draw_address(ia);
            draw_address(da);
            start_fetches(1'b1, 1'b1, ia, da);
            wait_fetches(4 + n, 3 + n, "random fetch pair");
            check_pair("random");
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/sysbus_pkg.sv
design/cache_line_pkg.sv
design/line_fetch_fsm.sv
design/beat_counter.sv
design/line_assembler.sv
design/line_fetcher.sv
design/bus_arbiter.sv
design/fetch_subsystem.sv
test/tb_memory_model.sv
test/tb_fetch_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and searches the log for the pass line.
rm -f sim.log
verilator --binary --timing --top-module tb_fetch_subsystem -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
